//--- logic/dap_pkg.sv
package dap_pkg;

    // AP register slots, word address within the AP space
    typedef enum logic [5:0] {
        CSW = 6'd0,
        TAR = 6'd1,
        DRW = 6'd3,
        BD0 = 6'd4,
        BD1 = 6'd5,
        BD2 = 6'd6,
        BD3 = 6'd7
    } ap_reg_e;

    // debug-port word address
    typedef enum logic [1:0] {
        CTRL_STAT = 2'd1,
        SELECT    = 2'd2,
        RDBUFF    = 2'd3
    } dp_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } bridge_state_e;

    typedef struct packed {
        logic [5:0]  addr;
        logic        rnw;
        logic [31:0] wdata;
    } ap_req_t;

    typedef struct packed {
        logic        sector;
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
        logic [2:0]  size;
        logic [6:0]  prot;
        logic        secen;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        slverr;
    } mem_rsp_t;

endpackage

//--- logic/dp_ap_select.sv
`timescale 1ns/100ps

module dp_ap_select
    import dap_pkg::*;
(
    input  logic        tck,
    input  logic        dbgrstn,
    input  logic        dp_upd,
    input  logic        dp_apnacc,
    input  logic [3:2]  dp_addr,
    input  logic        dp_rnw,
    input  logic [31:0] dp_wdata,
    output logic [31:0] dp_rdata,
    output logic        dp_slverr,
    output logic        ap_upd,
    output ap_req_t     ap_req,
    input  logic [31:0] ap_rdata,
    input  logic        ap_slverr,
    input  logic        ap_busy
);

    logic [3:0] ap_bank;
    logic       sticky_wait;
    logic       ap_blocked;
    logic       ap_issue;
    logic       dp_write;
    logic       dp_read;

    // a strobe already sent counts as busy until mem_ap reacts to it
    assign ap_blocked = ap_busy | ap_upd;
    assign ap_issue   = dp_upd & dp_apnacc & ~ap_blocked;
    assign dp_write   = dp_upd & ~dp_apnacc & ~dp_rnw;
    assign dp_read    = dp_upd & ~dp_apnacc & dp_rnw;

    always_ff @(posedge tck or negedge dbgrstn) begin
        if (!dbgrstn) begin
            ap_upd      <= 1'b0;
            ap_bank     <= 4'h0;
            sticky_wait <= 1'b0;
            dp_slverr   <= 1'b0;
        end else begin
            ap_upd <= ap_issue;
            if (dp_write && dp_addr == SELECT) begin
                ap_bank <= dp_wdata[7:4];
            end
            if (dp_upd && dp_apnacc && ap_blocked) begin
                sticky_wait <= 1'b1;
            end else if (dp_write && dp_addr == CTRL_STAT && dp_wdata[0]) begin
                sticky_wait <= 1'b0;
            end
            if (dp_read) begin
                dp_slverr <= (dp_addr == RDBUFF) & ap_slverr;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (ap_issue) begin
            ap_req.addr  <= {ap_bank, dp_addr};
            ap_req.rnw   <= dp_rnw;
            ap_req.wdata <= dp_wdata;
        end
        if (dp_read) begin
            case (dp_addr)
                CTRL_STAT: dp_rdata <= {30'b0, ap_busy, sticky_wait};
                SELECT:    dp_rdata <= {24'b0, ap_bank, 4'b0};
                RDBUFF:    dp_rdata <= ap_rdata;
                default:   dp_rdata <= dp_rdata;
            endcase
        end
    end

    // holds across the busy handshake with mem_ap
    ap_upd_idle: assert property (@(posedge tck) disable iff (!dbgrstn)
        ap_upd |-> !ap_busy);

endmodule

//--- logic/mem_ap.sv
`timescale 1ns/100ps

module mem_ap
    import dap_pkg::*;
#(
    parameter bit FIXED_SIZE = 1'b0
) (
    input  logic        tck,
    input  logic        dbgrstn,
    input  logic        ap_upd,
    input  ap_req_t     ap_req,
    output logic [31:0] ap_rdata,
    output logic        ap_slverr,
    output logic        ap_busy,
    output logic        tx_tog,
    output mem_req_t    tx_req,
    input  logic        rx_tog,
    input  mem_rsp_t    rx_rsp,
    input  logic        spiden,
    input  logic        deviceen
);

    logic        csw_dbgswen;
    logic [6:0]  csw_prot;
    logic [1:0]  csw_addrinc;
    logic        csw_sector;
    logic [2:0]  csw_size;
    logic [31:0] csw_word;
    logic [31:0] tar;
    logic        is_mem;
    logic        reg_acc;
    logic        launch;
    logic [2:0]  rx_sync;
    logic        rx_rec;
    logic        rx_rec_dly;
    mem_rsp_t    rsp_q;
    logic [1:0]  dis_sr;
    logic        done;

    assign is_mem  = ap_req.addr inside {DRW, BD0, BD1, BD2, BD3};
    assign reg_acc = ap_upd & ~ap_busy & ~is_mem;
    assign launch  = ap_upd & ~ap_busy & is_mem;

    // mode bits read as zero and bit 7 shows the transfer in progress
    assign csw_word = {csw_dbgswen, csw_prot, spiden, 11'b0, 4'b0, ap_busy,
                       deviceen, csw_addrinc, csw_sector, csw_size};

    always_ff @(posedge tck or negedge dbgrstn) begin
        if (!dbgrstn) begin
            csw_dbgswen <= 1'b0;
            csw_prot    <= 7'h0;
            csw_addrinc <= 2'h0;
            csw_sector  <= 1'b0;
            csw_size    <= 3'h2;
        end else if (reg_acc && ap_req.addr == CSW && !ap_req.rnw) begin
            csw_dbgswen <= ap_req.wdata[31];
            csw_prot    <= ap_req.wdata[30:24];
            csw_addrinc <= ap_req.wdata[5:4];
            csw_sector  <= ap_req.wdata[3];
            csw_size    <= FIXED_SIZE ? csw_size : ap_req.wdata[2:0];
        end
    end

    always_ff @(posedge tck or negedge dbgrstn) begin
        if (!dbgrstn) begin
            tar <= 32'h0;
        end else if (reg_acc && ap_req.addr == TAR && !ap_req.rnw) begin
            tar <= ap_req.wdata & {30'h3fff_ffff, {2{~FIXED_SIZE}}};
        end else if (launch && ap_req.addr == DRW && csw_addrinc == 2'h1) begin
            tar <= tar + (32'h1 << csw_size);
        end
    end

    // a disabled device fakes a failed response two cycles on
    assign done = rx_rec_dly | dis_sr[1];

    always_ff @(posedge tck or negedge dbgrstn) begin
        if (!dbgrstn) begin
            ap_busy    <= 1'b0;
            tx_tog     <= 1'b0;
            dis_sr     <= 2'b00;
            rx_sync    <= 3'b000;
            rx_rec_dly <= 1'b0;
        end else begin
            if (launch) begin
                ap_busy <= 1'b1;
            end else if (done) begin
                ap_busy <= 1'b0;
            end
            if (launch && deviceen) begin
                tx_tog <= ~tx_tog;
            end
            dis_sr     <= {dis_sr[0], launch & ~deviceen};
            rx_sync    <= {rx_sync[1:0], rx_tog};
            rx_rec_dly <= rx_rec;
        end
    end

    assign rx_rec = rx_sync[1] ^ rx_sync[2];

    always_ff @(posedge tck or negedge dbgrstn) begin
        if (!dbgrstn) begin
            ap_rdata  <= 32'h0;
            ap_slverr <= 1'b0;
        end else if (reg_acc) begin
            ap_slverr <= 1'b0;
            if (ap_req.rnw) begin
                ap_rdata <= (ap_req.addr == CSW) ? csw_word :
                            (ap_req.addr == TAR) ? tar : 32'h0;
            end
        end else if (done) begin
            ap_rdata  <= dis_sr[1] ? 32'h0 : rsp_q.rdata;
            ap_slverr <= dis_sr[1] ? 1'b1 : rsp_q.slverr;
        end
    end

    // request held stable until the bridge answers
    always_ff @(posedge tck) begin
        if (launch && deviceen) begin
            tx_req.sector <= csw_sector;
            tx_req.addr   <= (ap_req.addr == DRW) ? tar :
                             {tar[31:4], ap_req.addr[1:0], 2'b00};
            tx_req.write  <= ~ap_req.rnw;
            tx_req.wdata  <= ap_req.wdata;
            tx_req.size   <= csw_size;
            tx_req.prot   <= csw_prot;
            tx_req.secen  <= spiden;
        end
        if (rx_rec) begin
            rsp_q <= rx_rsp;
        end
    end

    tx_tog_with_busy: assert property (@(posedge tck) disable iff (!dbgrstn)
        $changed(tx_tog) |-> $rose(ap_busy));

endmodule

//--- logic/mem_bus_bridge.sv
`timescale 1ns/100ps

module mem_bus_bridge
    import dap_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic                         tck,
    input  logic                         dbgrstn,
    input  logic                         tx_tog,
    input  mem_req_t                     tx_req,
    output logic                         rx_tog,
    output mem_rsp_t                     rx_rsp,
    output logic                         sram_en,
    output logic [3:0]                   sram_we,
    output logic [$clog2(MEM_WORDS)-1:0] sram_addr,
    output logic [31:0]                  sram_wdata,
    input  logic [31:0]                  sram_rdata
);

    localparam int AW = $clog2(MEM_WORDS);

    bridge_state_e state;
    logic [2:0]    tx_sync;
    logic          tx_rec;
    logic          misaligned;
    logic          err;
    logic          err_q;
    logic [3:0]    lane_we;
    logic [31:0]   lane_wdata;

    assign tx_rec = tx_sync[1] ^ tx_sync[2];

    assign misaligned = (tx_req.size == 3'd1 && tx_req.addr[0]) ||
                        (tx_req.size == 3'd2 && tx_req.addr[1:0] != 2'b00);
    assign err = (tx_req.size > 3'd2) || misaligned ||
                 (tx_req.addr[31:2] >= 30'(MEM_WORDS)) ||
                 (tx_req.sector && !tx_req.secen);

    // narrow data comes low justified and is copied onto every lane
    always_comb begin
        case (tx_req.size)
            3'd0: begin
                lane_we    = 4'b0001 << tx_req.addr[1:0];
                lane_wdata = {4{tx_req.wdata[7:0]}};
            end
            3'd1: begin
                lane_we    = tx_req.addr[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{tx_req.wdata[15:0]}};
            end
            default: begin
                lane_we    = 4'b1111;
                lane_wdata = tx_req.wdata;
            end
        endcase
    end

    always_ff @(posedge tck or negedge dbgrstn) begin
        if (!dbgrstn) begin
            state   <= IDLE;
            tx_sync <= 3'b000;
            rx_tog  <= 1'b0;
            sram_en <= 1'b0;
            sram_we <= 4'h0;
            err_q   <= 1'b0;
        end else begin
            tx_sync <= {tx_sync[1:0], tx_tog};
            case (state)
                IDLE: begin
                    if (tx_rec) begin
                        err_q <= err;
                        if (err) begin
                            state <= RESPOND;
                        end else begin
                            state   <= ACCESS;
                            sram_en <= 1'b1;
                            sram_we <= tx_req.write ? lane_we : 4'h0;
                        end
                    end
                end
                ACCESS: begin
                    state   <= RESPOND;
                    sram_en <= 1'b0;
                    sram_we <= 4'h0;
                end
                RESPOND: begin
                    state  <= IDLE;
                    rx_tog <= ~rx_tog;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge tck) begin
        if (state == IDLE && tx_rec) begin
            sram_addr  <= tx_req.addr[AW+1:2];
            sram_wdata <= lane_wdata;
        end
        // sram output is valid here, one cycle after the access
        if (state == RESPOND) begin
            rx_rsp.rdata  <= err_q ? 32'h0 : sram_rdata;
            rx_rsp.slverr <= err_q;
        end
    end

    sram_en_in_access: assert property (@(posedge tck) disable iff (!dbgrstn)
        sram_en |-> state == ACCESS);

endmodule

//--- logic/dbg_sram.sv
`timescale 1ns/100ps

module dbg_sram #(
    parameter int MEM_WORDS = 64
) (
    input  logic                         tck,
    input  logic                         sram_en,
    input  logic [3:0]                   sram_we,
    input  logic [$clog2(MEM_WORDS)-1:0] sram_addr,
    input  logic [31:0]                  sram_wdata,
    output logic [31:0]                  sram_rdata
);

    logic [31:0] mem [MEM_WORDS];

    always_ff @(posedge tck) begin
        if (sram_en) begin
            for (int i = 0; i < 4; i++) begin
                if (sram_we[i]) begin
                    mem[sram_addr][8*i +: 8] <= sram_wdata[8*i +: 8];
                end
            end
            // old word on a write
            sram_rdata <= mem[sram_addr];
        end
    end

endmodule

//--- logic/dap_mem_top.sv
`timescale 1ns/100ps

module dap_mem_top
    import dap_pkg::*;
#(
    parameter bit FIXED_SIZE = 1'b0,
    parameter int MEM_WORDS  = 64
) (
    input  logic        tck,
    input  logic        dbgrstn,
    input  logic        dp_upd,
    input  logic        dp_apnacc,
    input  logic [3:2]  dp_addr,
    input  logic        dp_rnw,
    input  logic [31:0] dp_wdata,
    output logic [31:0] dp_rdata,
    output logic        dp_slverr,
    output logic        ap_busy,
    input  logic        spiden,
    input  logic        deviceen
);

    logic                         ap_upd;
    ap_req_t                      ap_req;
    logic [31:0]                  ap_rdata;
    logic                         ap_slverr;
    logic                         tx_tog;
    mem_req_t                     tx_req;
    logic                         rx_tog;
    mem_rsp_t                     rx_rsp;
    logic                         sram_en;
    logic [3:0]                   sram_we;
    logic [$clog2(MEM_WORDS)-1:0] sram_addr;
    logic [31:0]                  sram_wdata;
    logic [31:0]                  sram_rdata;

    dp_ap_select u_dp_ap_select (
        .tck       (tck),
        .dbgrstn   (dbgrstn),
        .dp_upd    (dp_upd),
        .dp_apnacc (dp_apnacc),
        .dp_addr   (dp_addr),
        .dp_rnw    (dp_rnw),
        .dp_wdata  (dp_wdata),
        .dp_rdata  (dp_rdata),
        .dp_slverr (dp_slverr),
        .ap_upd    (ap_upd),
        .ap_req    (ap_req),
        .ap_rdata  (ap_rdata),
        .ap_slverr (ap_slverr),
        .ap_busy   (ap_busy)
    );

    mem_ap #(
        .FIXED_SIZE (FIXED_SIZE)
    ) u_mem_ap (
        .tck       (tck),
        .dbgrstn   (dbgrstn),
        .ap_upd    (ap_upd),
        .ap_req    (ap_req),
        .ap_rdata  (ap_rdata),
        .ap_slverr (ap_slverr),
        .ap_busy   (ap_busy),
        .tx_tog    (tx_tog),
        .tx_req    (tx_req),
        .rx_tog    (rx_tog),
        .rx_rsp    (rx_rsp),
        .spiden    (spiden),
        .deviceen  (deviceen)
    );

    mem_bus_bridge #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_bus_bridge (
        .tck        (tck),
        .dbgrstn    (dbgrstn),
        .tx_tog     (tx_tog),
        .tx_req     (tx_req),
        .rx_tog     (rx_tog),
        .rx_rsp     (rx_rsp),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    dbg_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dbg_sram (
        .tck        (tck),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

endmodule

//--- sim/tb_dap_mem.sv
`timescale 1ns/100ps

module tb_dap_mem;

    localparam TEST_FILE = "sim/dap_mem_tests.txt";

    logic        tck;
    logic        dbgrstn;
    logic        dp_upd;
    logic        dp_apnacc;
    logic [3:2]  dp_addr;
    logic        dp_rnw;
    logic [31:0] dp_wdata;
    logic [31:0] dp_rdata;
    logic        dp_slverr;
    logic        ap_busy;
    logic        spiden;
    logic        deviceen;

    int cycles = 0;
    int cycle_limit = 0;
    int entry_no = 0;

    dap_mem_top #(
        .FIXED_SIZE (1'b0),
        .MEM_WORDS  (64)
    ) dut_i (
        .tck       (tck),
        .dbgrstn   (dbgrstn),
        .dp_upd    (dp_upd),
        .dp_apnacc (dp_apnacc),
        .dp_addr   (dp_addr),
        .dp_rnw    (dp_rnw),
        .dp_wdata  (dp_wdata),
        .dp_rdata  (dp_rdata),
        .dp_slverr (dp_slverr),
        .ap_busy   (ap_busy),
        .spiden    (spiden),
        .deviceen  (deviceen)
    );

    initial begin
        tck = 1'b0;
        forever #4 tck = ~tck;
    end

    // whole run is bounded by the number of entries in the test file
    always @(posedge tck) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run passed %0d cycles at entry %0d", cycle_limit, entry_no);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: entry %0d %s is %h, expected %h",
                     $time, entry_no, what, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic open_tests(output int fd);
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test file %0s", TEST_FILE);
            $display("Test failed");
            $fatal(1, "missing test file");
        end
    endtask

    // skips comment lines, returns the next entry
    task automatic fetch_line(input int fd, output bit have_line, output logic [63:0] kind,
                              output logic [5:0] addr, output logic rnw,
                              output logic [31:0] wdata, output logic [31:0] exp_data,
                              output logic exp_err);
        int            code;
        bit            at_end;
        logic [1023:0] rest;
        have_line = 1'b0;
        at_end    = 1'b0;
        while (!have_line && !at_end) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", addr, rnw, wdata, exp_data, exp_err);
                if (code != 5) begin
                    $display("test file entry of kind %0s has missing fields", kind);
                    $display("Test failed");
                    $fatal(1, "bad test file");
                end else begin
                    have_line = 1'b1;
                end
            end
        end
    endtask

    // one-cycle strobe, driven on the falling edge
    task automatic issue_strobe(input logic apnacc, input logic [1:0] addr,
                                input logic rnw, input logic [31:0] wdata);
        @(negedge tck);
        dp_upd    = 1'b1;
        dp_apnacc = apnacc;
        dp_addr   = addr;
        dp_rnw    = rnw;
        dp_wdata  = wdata;
        @(negedge tck);
        dp_upd = 1'b0;
    endtask

    task automatic read_dp_reg(input logic [1:0] addr, output logic [31:0] data,
                               output logic err);
        issue_strobe(1'b0, addr, 1'b1, 32'h0);
        data = dp_rdata;
        err  = dp_slverr;
    endtask

    task automatic run_ap_access(input logic [5:0] addr, input logic rnw,
                                 input logic [31:0] wdata, input logic retry,
                                 output logic [31:0] data, output logic err);
        // bank select first
        issue_strobe(1'b0, 2'd2, 1'b0, {24'h0, addr[5:2], 4'h0});
        issue_strobe(1'b1, addr[1:0], rnw, wdata);
        // ap_upd, then busy, one cycle each
        @(negedge tck);
        if (retry) begin
            check_value("busy before the retry", {31'h0, ap_busy}, 32'h1);
            issue_strobe(1'b1, addr[1:0], rnw, wdata);
        end
        while (ap_busy) begin
            @(negedge tck);
        end
        read_dp_reg(2'd3, data, err);
    endtask

    initial begin
        int          fd;
        int          n_entries;
        bit          have_line;
        logic [63:0] kind;
        logic [5:0]  addr;
        logic        rnw;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic        exp_err;
        logic [31:0] got_data;
        logic        got_err;

        dbgrstn   = 1'b0;
        dp_upd    = 1'b0;
        dp_apnacc = 1'b0;
        dp_addr   = 2'd0;
        dp_rnw    = 1'b0;
        dp_wdata  = 32'h0;
        spiden    = 1'b1;
        deviceen  = 1'b1;

        open_tests(fd);
        n_entries = 0;
        fetch_line(fd, have_line, kind, addr, rnw, wdata, exp_data, exp_err);
        while (have_line) begin
            n_entries++;
            fetch_line(fd, have_line, kind, addr, rnw, wdata, exp_data, exp_err);
        end
        $fclose(fd);
        cycle_limit = 200 * n_entries + 20;

        repeat (10) @(negedge tck);
        dbgrstn = 1'b1;

        open_tests(fd);
        fetch_line(fd, have_line, kind, addr, rnw, wdata, exp_data, exp_err);
        while (have_line) begin
            entry_no++;
            if (kind == "CTL") begin
                @(negedge tck);
                spiden   = wdata[0];
                deviceen = wdata[1];
            end else if (kind == "DP") begin
                if (rnw) begin
                    read_dp_reg(addr[1:0], got_data, got_err);
                    check_value("DP read data", got_data, exp_data);
                    check_value("DP slverr", {31'h0, got_err}, {31'h0, exp_err});
                end else begin
                    issue_strobe(1'b0, addr[1:0], 1'b0, wdata);
                end
            end else if (kind == "AP" || kind == "AB") begin
                run_ap_access(addr, rnw, wdata, kind == "AB", got_data, got_err);
                if (rnw) begin
                    check_value("AP read data", got_data, exp_data);
                end
                check_value("AP slverr", {31'h0, got_err}, {31'h0, exp_err});
            end else begin
                $display("unknown entry kind %0s in the test file", kind);
                $display("Test failed");
                $fatal(1, "bad test file");
            end
            fetch_line(fd, have_line, kind, addr, rnw, wdata, exp_data, exp_err);
        end
        $fclose(fd);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tb.f
logic/dap_pkg.sv
logic/dp_ap_select.sv
logic/mem_ap.sv
logic/mem_bus_bridge.sv
logic/dbg_sram.sv
logic/dap_mem_top.sv
sim/tb_dap_mem.sv

//--- sim/dap_mem_tests.txt
# kind addr rnw wdata exp_data exp_err, all hex; AP addr is the 6-bit AP word address
# CTL wdata bit0 spiden bit1 deviceen; AB is an AP access with a dropped retry while busy
CTL 00 0 00000003 00000000 0
AP  00 1 00000000 00800042 0
AP  00 0 00000012 00000000 0
AP  00 1 00000000 00800052 0
AP  01 0 00000013 00000000 0
AP  01 1 00000000 00000013 0
AP  01 0 00000010 00000000 0
AP  03 0 11223344 00000000 0
AP  03 0 55667788 00000000 0
AP  01 1 00000000 00000018 0
AP  01 0 00000010 00000000 0
AP  03 1 00000000 11223344 0
AP  03 1 00000000 55667788 0
# byte and halfword lanes
AP  00 0 00000000 00000000 0
AP  01 0 00000011 00000000 0
AP  03 0 000000ab 00000000 0
AP  00 0 00000001 00000000 0
AP  01 0 00000016 00000000 0
AP  03 0 0000cdef 00000000 0
AP  01 0 00000015 00000000 0
AP  03 0 00001234 00000000 1
AP  00 0 00000003 00000000 0
AP  03 1 00000000 00000000 1
AP  00 0 00000002 00000000 0
AP  01 0 00000010 00000000 0
AP  03 1 00000000 1122ab44 0
# banked data registers
AP  05 1 00000000 cdef7788 0
AP  06 0 a5a50006 00000000 0
AP  07 0 5a5a0007 00000000 0
AP  04 1 00000000 1122ab44 0
AP  06 1 00000000 a5a50006 0
AP  07 1 00000000 5a5a0007 0
DP  2 1 00000000 00000010 0
AP  01 1 00000000 00000010 0
# range, secure and disabled device errors
AP  01 0 00000100 00000000 0
AP  03 1 00000000 00000000 1
AP  00 0 0000000a 00000000 0
AP  01 0 00000010 00000000 0
CTL 00 0 00000002 00000000 0
AP  03 1 00000000 00000000 1
CTL 00 0 00000003 00000000 0
AP  03 1 00000000 1122ab44 0
CTL 00 0 00000001 00000000 0
AP  03 1 00000000 00000000 1
CTL 00 0 00000003 00000000 0
# sticky wait flag
AP  00 0 00000002 00000000 0
AB  03 1 00000000 1122ab44 0
DP  1 1 00000000 00000001 0
DP  1 0 00000001 00000000 0
DP  1 1 00000000 00000000 0
